/* scan_top.f */
src/scan_pkg.sv
src/lb_decode.sv
src/delay_scanner.sv
src/result_ram.sv
src/readback_mux.sv
src/scan_top.sv
sim/scan_props.sv
sim/scan_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = scan_tb
FILELIST   = scan_top.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/scan_tb.sv */
//////////////////////////////
// scanner testbench
// table-driven bus stimulus, ADC responder
// and a reference model of results and mirrors
//////////////////////////////
module scan_tb;

	localparam logic [3:0] op_wr      = 4'd0;
	localparam logic [3:0] op_rd      = 4'd1;
	localparam logic [3:0] op_mask    = 4'd2;
	localparam logic [3:0] op_lane    = 4'd3;
	localparam logic [3:0] op_scan    = 4'd4;
	localparam logic [3:0] op_results = 4'd5;
	localparam logic [3:0] op_mirrors = 4'd6;

	typedef struct packed {
		logic [3:0]  op;
		logic [11:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} step_t;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic [11:0] lb_addr = '0;
	logic        lb_write = 1'b0;
	logic [31:0] lb_data = '0;
	logic [7:0]  adc_val = '0;
	logic [7:0]  odata;
	logic [7:0]  mask_out;
	logic [3:0]  hw_addr;
	logic [4:0]  hw_data;
	logic        hw_strobe;

	step_t       steps[$];
	int          key_a;
	int          key_b;
	int          scan_no = 0;
	logic        model_autoset = 1'b0;
	logic [7:0]  exp_res [512];
	logic [4:0]  exp_best [16];
	logic [4:0]  exp_mirror [16];

	// strobe monitor state
	logic        in_scan = 1'b0;
	int          per_lane = 32;
	int          seq_lane = 0;
	int          seq_idx = 0;
	int          strobe_cnt = 0;
	logic        manual_seen = 1'b0;
	logic [3:0]  manual_addr = '0;
	logic [4:0]  manual_data = '0;
	logic [4:0]  exp_tap;
	logic [7:0]  exp_mask;

	scan_top dut0 (
		.clk, .rst_n, .lb_addr, .lb_write, .lb_data, .adc_val,
		.odata, .mask_out, .hw_addr, .hw_data, .hw_strobe
	);

	always #4 clk = ~clk;

	// ADC quality per lane and tap, coarse steps so ties happen
	function automatic logic [7:0] adc_rule(input int lane, input int tap, input int pass);
		int v;
		v = lane * 29 + tap * key_a + tap * tap * key_b + pass * 71;
		return v[7:0] & 8'hf8;
	endfunction

	task automatic fail_run(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
			fail_run("value mismatch");
		end
	endtask

	// ADC answers the tap that was last applied
	always @(posedge clk) begin
		if (hw_strobe)
			adc_val <= adc_rule(int'(hw_addr), int'(hw_data), scan_no);
	end

	always @(negedge clk) begin
		if (rst_n && hw_strobe) begin
			if (in_scan) begin
				// taps 0..31 per lane, then the best tap when autoset is on
				if (seq_idx < 32)
					exp_tap = seq_idx[4:0];
				else
					exp_tap = exp_best[seq_lane];
				exp_mask = 8'd1 << seq_lane[2:0];
				check("hw_addr", 32'(seq_lane), 32'(hw_addr));
				check("hw_data", 32'(exp_tap), 32'(hw_data));
				check("mask_out", 32'(exp_mask), 32'(mask_out));
				strobe_cnt++;
				if (seq_idx == per_lane - 1) begin
					seq_idx = 0;
					seq_lane++;
				end else begin
					seq_idx++;
				end
			end else begin
				manual_addr = hw_addr;
				manual_data = hw_data;
				manual_seen = 1'b1;
			end
		end
	end

	task automatic bus_write(input logic [11:0] a, input logic [31:0] d);
		@(posedge clk);
		lb_addr  <= a;
		lb_data  <= d;
		lb_write <= 1'b1;
		@(posedge clk);
		lb_write <= 1'b0;
	endtask

	// read data lands three cycles after the address
	task automatic bus_read(input logic [11:0] a, output logic [7:0] v);
		@(posedge clk);
		lb_addr <= a;
		repeat (3) @(posedge clk);
		@(negedge clk);
		v = odata;
	endtask

	task automatic wait_status(input logic val, input int limit);
		int n;
		@(posedge clk);
		lb_addr <= 12'd4;
		repeat (3) @(posedge clk);
		n = 0;
		while (n < limit) begin
			@(negedge clk);
			if (odata[0] == val)
				break;
			n++;
		end
		if (n == limit)
			fail_run("timed out waiting for the scan status bit to change");
	endtask

	task automatic lane_write(input logic [11:0] a, input logic [4:0] tap);
		int n;
		manual_seen = 1'b0;
		bus_write(a, 32'(tap));
		n = 0;
		while (!manual_seen && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (!manual_seen)
			fail_run("no hw_strobe seen after a lane write");
		check("hw_addr", 32'(a[3:0]), 32'(manual_addr));
		check("hw_data", 32'(tap), 32'(manual_data));
		exp_mirror[a[3:0]] = tap;
	endtask

	task automatic run_scan(input logic inject);
		int best;
		scan_no++;
		for (int l = 0; l < 16; l++) begin
			best = 0;
			for (int t = 0; t < 32; t++) begin
				exp_res[l * 32 + t] = adc_rule(l, t, scan_no);
				if (exp_res[l * 32 + t] > exp_res[l * 32 + best])
					best = t;
			end
			exp_best[l] = best[4:0];
		end
		per_lane   = model_autoset ? 33 : 32;
		seq_lane   = 0;
		seq_idx    = 0;
		strobe_cnt = 0;
		in_scan    = 1'b1;
		bus_write(12'd4, 32'd1);
		wait_status(1'b1, 50);
		if (inject) begin
			// both must be dropped while the sweep runs
			bus_write(12'd19, 32'd7);
			bus_write(12'd4, 32'd1);
		end
		wait_status(1'b0, 8000);
		in_scan = 1'b0;
		check("hw_strobe count", 32'(16 * per_lane), 32'(strobe_cnt));
		if (model_autoset) begin
			for (int l = 0; l < 16; l++)
				exp_mirror[l] = exp_best[l];
		end
	endtask

	task automatic verify_results();
		logic [7:0] v;
		for (int a = 0; a < 512; a++) begin
			bus_read(12'h800 | 12'(a), v);
			check("odata", 32'(exp_res[a]), 32'(v));
		end
	endtask

	task automatic verify_mirrors();
		logic [7:0] v;
		for (int a = 0; a < 16; a++) begin
			bus_read(12'd16 + 12'(a), v);
			check("odata", 32'(exp_mirror[a]), 32'(v));
		end
	endtask

	task automatic add_step(input logic [3:0] op, input logic [11:0] addr,
			input logic [31:0] data, input logic [31:0] exp);
		steps.push_back({op, addr, data, exp});
	endtask

	task automatic build_steps();
		// idle state after reset
		add_step(op_rd, 12'd4, 32'd0, 32'h00);
		add_step(op_rd, 12'd16, 32'd0, 32'h00);
		add_step(op_rd, 12'd31, 32'd0, 32'h00);
		add_step(op_mask, 12'd0, 32'd0, 32'h00);
		add_step(op_rd, 12'd0, 32'd0, 32'h55);
		add_step(op_rd, 12'd3, 32'd0, 32'h55);
		add_step(op_rd, 12'h7ff, 32'd0, 32'h55);
		// host mask and manual taps
		add_step(op_wr, 12'd5, 32'h0000_00a5, 32'd0);
		add_step(op_mask, 12'd0, 32'd0, 32'ha5);
		add_step(op_lane, 12'h012, 32'd9, 32'd0);
		add_step(op_lane, 12'h01f, 32'd30, 32'd0);
		add_step(op_mirrors, 12'd0, 32'd0, 32'd0);
		// scan with autoset
		add_step(op_wr, 12'd6, 32'd1, 32'd0);
		add_step(op_scan, 12'd0, 32'd0, 32'd0);
		add_step(op_results, 12'd0, 32'd0, 32'd0);
		add_step(op_mirrors, 12'd0, 32'd0, 32'd0);
		add_step(op_mask, 12'd0, 32'd0, 32'ha5);
		// scan without autoset, with writes landing mid-scan
		add_step(op_wr, 12'd5, 32'h0000_ff3c, 32'd0);
		add_step(op_wr, 12'd6, 32'd0, 32'd0);
		add_step(op_scan, 12'd0, 32'd1, 32'd0);
		add_step(op_results, 12'd0, 32'd0, 32'd0);
		add_step(op_mirrors, 12'd0, 32'd0, 32'd0);
		add_step(op_mask, 12'd0, 32'd0, 32'h3c);
		add_step(op_rd, 12'd4, 32'd0, 32'h00);
	endtask

	task automatic run_step(input step_t s);
		logic [7:0] v;
		case (s.op)
			op_wr: begin
				bus_write(s.addr, s.data);
				if (s.addr == 12'd6)
					model_autoset = s.data[0];
			end
			op_rd: begin
				bus_read(s.addr, v);
				check("odata", s.exp, 32'(v));
			end
			op_mask: begin
				repeat (4) @(posedge clk);
				@(negedge clk);
				check("mask_out", s.exp, 32'(mask_out));
			end
			op_lane: lane_write(s.addr, s.data[4:0]);
			op_scan: run_scan(s.data[0]);
			op_results: verify_results();
			op_mirrors: verify_mirrors();
			default: fail_run("unknown operation in the stimulus table");
		endcase
	endtask

	initial begin
		void'($urandom(32322));
		key_a = 1 + int'($urandom % 32'd50);
		key_b = int'($urandom % 32'd50);
		for (int l = 0; l < 16; l++)
			exp_mirror[l] = '0;
		build_steps();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		foreach (steps[i])
			run_step(steps[i]);
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* sim/scan_props.sv */
//////////////////////////////
// scanner properties
// strobe width, scan mask and reset state
//////////////////////////////
module scan_props (
	input logic       clk,
	input logic       rst_n,
	input logic       hw_strobe,
	input logic       scan_running,
	input logic [7:0] mask_out,
	input logic [7:0] odata
);

	// every strobe is a single-cycle pulse
	strobe_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		hw_strobe |=> !hw_strobe
	) else $error("hw_strobe held high for two cycles");

	// mask_out lags scan_running by one register
	scan_mask_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(scan_running) |-> $onehot0(mask_out)
	) else $error("mask_out not one-hot during a scan");

	// outputs sit at zero once reset has been seen on an edge
	reset_outputs: assert property (
		@(posedge clk)
		(!rst_n && $past(!rst_n)) |-> (odata == 8'h00 && mask_out == 8'h00 && !hw_strobe)
	) else $error("outputs not zero during reset");

endmodule

bind scan_top scan_props props0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.hw_strobe    (hw_strobe),
	.scan_running (scan_running),
	.mask_out     (mask_out),
	.odata        (odata)
);

/* src/scan_top.sv */
//////////////////////////////
// scanner subsystem top
// local bus decode, delay scanner, results and readback
//////////////////////////////
module scan_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [scan_pkg::lb_addr_w-1:0] lb_addr,
	input  logic                           lb_write,
	input  logic [scan_pkg::lb_data_w-1:0] lb_data,
	input  logic [scan_pkg::res_w-1:0]     adc_val,
	output logic [scan_pkg::res_w-1:0]     odata,
	output logic [scan_pkg::mask_w-1:0]    mask_out,
	output logic [scan_pkg::lane_w-1:0]    hw_addr,
	output logic [scan_pkg::tap_w-1:0]     hw_data,
	output logic                           hw_strobe
);
	import scan_pkg::*;

	logic                  scan_trigger;
	logic [mask_w-1:0]     host_mask;
	logic                  autoset_enable;
	logic                  lane_write;
	logic [lane_w-1:0]     lane_sel;
	logic [tap_w-1:0]      lane_tap;
	logic [lb_addr_w-1:0]  rd_addr;
	logic                  scan_running;
	logic [mask_w-1:0]     scan_mask;
	logic                  res_we;
	logic [res_addr_w-1:0] res_waddr;
	logic [res_w-1:0]      res_wdata;
	logic [res_w-1:0]      res_rdata;
	logic [tap_w-1:0]      mirror_rd_val;

	lb_decode u_decode (
		.clk, .rst_n, .lb_addr, .lb_write, .lb_data,
		.scan_trigger, .host_mask, .autoset_enable,
		.lane_write, .lane_sel, .lane_tap, .rd_addr
	);

	delay_scanner u_scanner (
		.clk, .rst_n, .scan_trigger, .autoset_enable,
		.lane_write, .lane_sel, .lane_tap, .adc_val,
		.mirror_rd_lane (rd_addr[lane_w-1:0]),
		.hw_addr, .hw_data, .hw_strobe, .scan_running, .scan_mask,
		.res_we, .res_waddr, .res_wdata, .mirror_rd_val
	);

	// read side is addressed straight from the bus pins
	result_ram u_ram (
		.clk,
		.we    (res_we),
		.waddr (res_waddr),
		.wdata (res_wdata),
		.raddr (lb_addr[res_addr_w-1:0]),
		.rdata (res_rdata)
	);

	readback_mux u_readback (
		.clk, .rst_n, .rd_addr, .res_rdata, .mirror_rd_val,
		.scan_running, .scan_mask, .host_mask, .mask_out, .odata
	);

endmodule

/* src/readback_mux.sv */
//////////////////////////////
// readback mux
// lane mask select and registered host read data
//////////////////////////////
module readback_mux (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [scan_pkg::lb_addr_w-1:0] rd_addr,
	input  logic [scan_pkg::res_w-1:0]     res_rdata,
	input  logic [scan_pkg::tap_w-1:0]     mirror_rd_val,
	input  logic                           scan_running,
	input  logic [scan_pkg::mask_w-1:0]    scan_mask,
	input  logic [scan_pkg::mask_w-1:0]    host_mask,
	output logic [scan_pkg::mask_w-1:0]    mask_out,
	output logic [scan_pkg::res_w-1:0]     odata
);
	import scan_pkg::*;

	logic mirror_hit;

	// scanner owns the mask only while a sweep runs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mask_out <= '0;
		else
			mask_out <= scan_running ? scan_mask : host_mask;
	end

	assign mirror_hit = rd_addr[lb_addr_w-1:lane_w] == addr_lane_base[lb_addr_w-1:lane_w];

	// read map, results take the whole upper half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			odata <= '0;
		end else begin
			if (rd_addr[lb_addr_w-1])
				odata <= res_rdata;
			else if (mirror_hit)
				odata <= {{(res_w - tap_w){1'b0}}, mirror_rd_val};
			else if (rd_addr == addr_trigger)
				odata <= {{(res_w - 1){1'b0}}, scan_running};
			else
				odata <= idle_pattern;
		end
	end

endmodule

/* src/result_ram.sv */
//////////////////////////////
// result memory
// 512 x 8 scan results, one write port, registered read
//////////////////////////////
module result_ram (
	input  logic                            clk,
	input  logic                            we,
	input  logic [scan_pkg::res_addr_w-1:0] waddr,
	input  logic [scan_pkg::res_w-1:0]      wdata,
	input  logic [scan_pkg::res_addr_w-1:0] raddr,
	output logic [scan_pkg::res_w-1:0]      rdata
);
	import scan_pkg::*;

	logic [res_w-1:0] mem [2**res_addr_w];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// read data lands one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* src/delay_scanner.sv */
//////////////////////////////
// delay scanner
// sweeps every lane through all taps, records the ADC quality
// and optionally moves each lane to its best tap
//////////////////////////////
module delay_scanner (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            scan_trigger,
	input  logic                            autoset_enable,
	input  logic                            lane_write,
	input  logic [scan_pkg::lane_w-1:0]     lane_sel,
	input  logic [scan_pkg::tap_w-1:0]      lane_tap,
	input  logic [scan_pkg::res_w-1:0]      adc_val,
	input  logic [scan_pkg::lane_w-1:0]     mirror_rd_lane,
	output logic [scan_pkg::lane_w-1:0]     hw_addr,
	output logic [scan_pkg::tap_w-1:0]      hw_data,
	output logic                            hw_strobe,
	output logic                            scan_running,
	output logic [scan_pkg::mask_w-1:0]     scan_mask,
	output logic                            res_we,
	output logic [scan_pkg::res_addr_w-1:0] res_waddr,
	output logic [scan_pkg::res_w-1:0]      res_wdata,
	output logic [scan_pkg::tap_w-1:0]      mirror_rd_val
);
	import scan_pkg::*;

	logic [st_w-1:0]     state;
	logic [lane_w-1:0]   lane;
	logic [tap_w-1:0]    tap;
	logic [settle_w-1:0] timer;
	logic [res_w-1:0]    best_val;
	logic [tap_w-1:0]    best_tap;
	logic [tap_w-1:0]    mirror [num_lanes];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			lane         <= '0;
			tap          <= '0;
			timer        <= '0;
			best_val     <= '0;
			best_tap     <= '0;
			scan_running <= 1'b0;
			hw_strobe    <= 1'b0;
			hw_addr      <= '0;
			hw_data      <= '0;
			res_we       <= 1'b0;
			for (int i = 0; i < num_lanes; i++)
				mirror[i] <= '0;
		end else begin
			hw_strobe <= 1'b0;
			res_we    <= 1'b0;
			case (state)
				st_idle: begin
					// a trigger wins over a lane write landing in the same cycle
					if (scan_trigger) begin
						scan_running <= 1'b1;
						lane         <= '0;
						tap          <= '0;
						state        <= st_strobe;
					end else if (lane_write) begin
						hw_strobe        <= 1'b1;
						hw_addr          <= lane_sel;
						hw_data          <= lane_tap;
						mirror[lane_sel] <= lane_tap;
					end
				end
				st_strobe: begin
					hw_strobe <= 1'b1;
					hw_addr   <= lane;
					hw_data   <= tap;
					timer     <= settle_w'(settle_cycles - 1);
					state     <= st_settle;
				end
				st_settle: begin
					if (timer == '0)
						state <= st_sample;
					else
						timer <= timer - 1'b1;
				end
				st_sample: begin
					res_we <= 1'b1;
					// strict compare keeps the lowest tap on a tie
					if (tap == '0 || adc_val > best_val) begin
						best_val <= adc_val;
						best_tap <= tap;
					end
					if (tap == tap_w'(num_taps - 1)) begin
						timer <= settle_w'(settle_cycles - 1);
						state <= st_lane_done;
					end else begin
						tap   <= tap + 1'b1;
						state <= st_strobe;
					end
				end
				st_lane_done: begin
					// best tap goes out on the first cycle, then it settles
					if (autoset_enable && timer == settle_w'(settle_cycles - 1)) begin
						hw_strobe    <= 1'b1;
						hw_addr      <= lane;
						hw_data      <= best_tap;
						mirror[lane] <= best_tap;
					end
					if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (lane == lane_w'(num_lanes - 1)) begin
						scan_running <= 1'b0;
						state        <= st_idle;
					end else begin
						lane  <= lane + 1'b1;
						tap   <= '0;
						state <= st_strobe;
					end
				end
				default: begin
					scan_running <= 1'b0;
					state        <= st_idle;
				end
			endcase
		end
	end

	// result write payload, qualified by res_we
	always_ff @(posedge clk) begin
		if (state == st_sample) begin
			res_waddr <= {lane, tap};
			res_wdata <= adc_val;
		end
	end

	// one-hot on the lane low bits
	assign scan_mask = {{(mask_w - 1){1'b0}}, 1'b1} << lane[2:0];

	assign mirror_rd_val = mirror[mirror_rd_lane];

endmodule

/* src/lb_decode.sv */
//////////////////////////////
// local bus decode
// registers the bus and turns writes into host controls
//////////////////////////////
module lb_decode (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [scan_pkg::lb_addr_w-1:0] lb_addr,
	input  logic                           lb_write,
	input  logic [scan_pkg::lb_data_w-1:0] lb_data,
	output logic                           scan_trigger,
	output logic [scan_pkg::mask_w-1:0]    host_mask,
	output logic                           autoset_enable,
	output logic                           lane_write,
	output logic [scan_pkg::lane_w-1:0]    lane_sel,
	output logic [scan_pkg::tap_w-1:0]     lane_tap,
	output logic [scan_pkg::lb_addr_w-1:0] rd_addr
);
	import scan_pkg::*;

	logic [lb_addr_w-1:0] addr_q;
	logic                 write_q;
	host_word_u           data_q;
	logic                 lane_hit;

	// first stage of input registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q  <= '0;
			write_q <= 1'b0;
		end else begin
			addr_q  <= lb_addr;
			write_q <= lb_write;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= lb_data;
	end

	// second stage lines the read address up with the result memory
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_addr <= '0;
		else
			rd_addr <= addr_q;
	end

	// host registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_trigger   <= 1'b0;
			host_mask      <= '0;
			autoset_enable <= 1'b0;
		end else begin
			scan_trigger <= write_q && (addr_q == addr_trigger);
			if (write_q && (addr_q == addr_mask))
				host_mask <= data_q.as_mask.mask;
			if (write_q && (addr_q == addr_autoset))
				autoset_enable <= data_q.raw[0];
		end
	end

	// lane taps live at 16..31, the scanner registers the write itself
	assign lane_hit   = addr_q[lb_addr_w-1:lane_w] == addr_lane_base[lb_addr_w-1:lane_w];
	assign lane_write = write_q && lane_hit;
	assign lane_sel   = addr_q[lane_w-1:0];
	assign lane_tap   = data_q.as_tap.tap;

endmodule

/* src/scan_pkg.sv */
//////////////////////////////
// scan package
// bus map, sizes and timing for the delay-tap scanner
//////////////////////////////
package scan_pkg;

	// local bus
	localparam int lb_addr_w = 12;
	localparam int lb_data_w = 32;

	// lanes, taps and samples
	localparam int lane_w     = 4;
	localparam int tap_w      = 5;
	localparam int num_lanes  = 1 << lane_w;
	localparam int num_taps   = 1 << tap_w;
	localparam int res_w      = 8;
	localparam int mask_w     = 8;
	// lane in the high bits, tap in the low bits
	localparam int res_addr_w = lane_w + tap_w;

	// delay line settling, counted from the strobe
	localparam int settle_cycles = 4;
	localparam int settle_w      = $clog2(settle_cycles + 1);

	// register map
	localparam logic [lb_addr_w-1:0] addr_trigger   = 12'd4;
	localparam logic [lb_addr_w-1:0] addr_mask      = 12'd5;
	localparam logic [lb_addr_w-1:0] addr_autoset   = 12'd6;
	localparam logic [lb_addr_w-1:0] addr_lane_base = 12'd16;
	localparam logic [res_w-1:0]     idle_pattern   = 8'h55;

	// sweep FSM encoding
	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_idle      = 3'd0;
	localparam logic [st_w-1:0] st_strobe    = 3'd1;
	localparam logic [st_w-1:0] st_settle    = 3'd2;
	localparam logic [st_w-1:0] st_sample    = 3'd3;
	localparam logic [st_w-1:0] st_lane_done = 3'd4;

	// one bus word, read as a lane mask or as a delay tap
	typedef union packed {
		logic [lb_data_w-1:0] raw;
		struct packed {
			logic [lb_data_w-mask_w-1:0] unused;
			logic [mask_w-1:0]           mask;
		} as_mask;
		struct packed {
			logic [lb_data_w-tap_w-1:0] unused;
			logic [tap_w-1:0]           tap;
		} as_tap;
	} host_word_u;

endpackage
